//--- src/surf_id_config.svh
`ifndef SURF_ID_CONFIG_SVH
`define SURF_ID_CONFIG_SVH

// identification words
`define SURF_DEVICE 32'h53555246
`define SURF_VERSION 32'h0001_0003

// serial chip identifier, shifted out lsb first
`define SURF_DNA_WIDTH 96
`define SURF_DNA_VALUE 96'h4d2c_19a7_e803_5b6f_0c91_d4e2

// clock monitor
`define SURF_NUM_CLKMON 4
// window length in wb_clk_i cycles
`define SURF_CLKMON_WINDOW 1024
// edges per toggle of the flag in each monitored domain
`define SURF_CLKMON_PRESCALE 8

`endif

//--- src/surf_id_pkg.sv
package surf_id_pkg;

    // classic Wishbone request as seen by every slave block
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [11:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } wb_req_t;

    // slave response, read data is only meaningful while ack is high
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // word index inside a 64-byte region, address bits 5:2
    typedef logic [3:0] reg_idx_t;

endpackage

//--- src/serial_id_reg.sv
`timescale 1ns/100ps
`include "surf_id_config.svh"

module serial_id_reg (
    input  logic wb_clk_i,
    input  logic load_i,
    input  logic shift_i,
    output logic dout_o
);

    localparam int DNA_W = `SURF_DNA_WIDTH;

    // zero at power-up, like the device primitive before its first read
    logic [DNA_W-1:0] dna_sr = '0;

    always_ff @(posedge wb_clk_i) begin
        if (load_i) begin
            dna_sr <= `SURF_DNA_VALUE;
        end else if (shift_i) begin
            dna_sr <= {1'b0, dna_sr[DNA_W-1:1]};
        end
    end

    // lsb is presented first
    assign dout_o = dna_sr[0];

endmodule

//--- src/surf_id_regs.sv
`timescale 1ns/100ps
`include "surf_id_config.svh"

module surf_id_regs (
    input  logic                          wb_clk_i,
    input  logic                          wb_rst_i,
    input  surf_id_pkg::wb_req_t          req_i,
    output surf_id_pkg::wb_rsp_t          rsp_o,
    input  logic                          dna_bit_i,
    output logic                          dna_load_o,
    output logic                          dna_shift_o,
    input  logic [`SURF_NUM_CLKMON-1:0]   clk_running_i
);

    import surf_id_pkg::*;

    localparam int NUM_CLK = `SURF_NUM_CLKMON;

    // word offsets, the region repeats every four words
    localparam logic [1:0] W_DEVICE  = 2'd0;
    localparam logic [1:0] W_VERSION = 2'd1;
    localparam logic [1:0] W_DNA     = 2'd2;
    localparam logic [1:0] W_STATUS  = 2'd3;

    reg_idx_t    idx;
    logic        region_sel;
    logic        req_hit;
    logic        dna_word;
    logic        ack_q;
    logic        load_q;
    logic        shift_q;
    logic [31:0] rdata;

    assign idx        = reg_idx_t'(req_i.adr[5:2]);
    assign region_sel = ~req_i.adr[6];
    assign req_hit    = req_i.cyc & req_i.stb & region_sel;
    assign dna_word   = (idx[1:0] == W_DNA);

    // single cycle ack, low again after each ack even with stb held
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_hit & ~ack_q;
        end
    end

    // identifier pulses follow the acked access by one cycle
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            load_q  <= 1'b0;
            shift_q <= 1'b0;
        end else begin
            load_q  <= ack_q & req_hit & req_i.we & dna_word
                       & req_i.sel[3] & req_i.dat[31];
            shift_q <= ack_q & req_hit & ~req_i.we & dna_word;
        end
    end

    always_comb begin
        case (idx[1:0])
            W_DEVICE:  rdata = `SURF_DEVICE;
            W_VERSION: rdata = `SURF_VERSION;
            W_DNA:     rdata = {31'd0, dna_bit_i};
            W_STATUS:  rdata = {{(32-NUM_CLK){1'b0}}, clk_running_i};
            default:   rdata = 32'd0;
        endcase
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.dat   = rdata;
    assign dna_load_o  = load_q;
    assign dna_shift_o = shift_q;

endmodule

//--- src/clock_mon.sv
`timescale 1ns/100ps
`include "surf_id_config.svh"

module clock_mon (
    input  logic                          wb_clk_i,
    input  logic                          wb_rst_i,
    input  surf_id_pkg::wb_req_t          req_i,
    output surf_id_pkg::wb_rsp_t          rsp_o,
    input  logic [`SURF_NUM_CLKMON-1:0]   mon_clk_i,
    output logic [`SURF_NUM_CLKMON-1:0]   clk_running_o
);

    import surf_id_pkg::*;

    localparam int NUM_CLK = `SURF_NUM_CLKMON;
    localparam int PRE     = `SURF_CLKMON_PRESCALE;
    localparam int PRE_W   = $clog2(PRE);
    localparam int WINDOW  = `SURF_CLKMON_WINDOW;
    localparam int WIN_W   = $clog2(WINDOW);
    localparam int CNT_W   = WIN_W + 1;
    localparam int SEL_W   = $clog2(NUM_CLK);
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(WINDOW - 1);
    // running flags sit right after the count words, at 0x50
    localparam reg_idx_t IDX_RUNNING = reg_idx_t'(NUM_CLK);

    logic [NUM_CLK-1:0]            tog;
    logic [NUM_CLK-1:0]            sync_a;
    logic [NUM_CLK-1:0]            sync_b;
    logic [NUM_CLK-1:0]            sync_c;
    logic [NUM_CLK-1:0]            tog_edge;
    logic [NUM_CLK-1:0][CNT_W-1:0] cnt;
    logic [NUM_CLK-1:0][CNT_W-1:0] cnt_next;
    logic [NUM_CLK-1:0][CNT_W-1:0] latched;
    logic [NUM_CLK-1:0]            running;
    logic [WIN_W-1:0]              win_cnt;
    logic                          win_end;
    reg_idx_t                      idx;
    logic                          ack_q;
    logic [31:0]                   rdata;

    for (genvar g = 0; g < NUM_CLK; g++) begin : g_pre
        logic [PRE_W-1:0] pre = '0;
        logic             flag = 1'b0;

        // flag toggles once per PRE edges of the monitored clock
        always_ff @(posedge mon_clk_i[g]) begin
            pre <= pre + PRE_W'(1);
            if (pre == PRE_W'(PRE - 1)) begin
                flag <= ~flag;
            end
        end

        assign tog[g] = flag;
    end

    assign tog_edge = sync_b ^ sync_c;
    assign win_end  = (win_cnt == WIN_LAST);

    always_comb begin
        for (int n = 0; n < NUM_CLK; n++) begin
            cnt_next[n] = cnt[n] + CNT_W'(tog_edge[n]);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sync_a  <= '0;
            sync_b  <= '0;
            sync_c  <= '0;
            win_cnt <= '0;
            cnt     <= '0;
            latched <= '0;
            running <= '0;
        end else begin
            sync_a  <= tog;
            sync_b  <= sync_a;
            sync_c  <= sync_b;
            win_cnt <= win_end ? '0 : win_cnt + WIN_W'(1);
            for (int n = 0; n < NUM_CLK; n++) begin
                if (win_end) begin
                    latched[n] <= cnt_next[n];
                    running[n] <= (cnt_next[n] != '0);
                    cnt[n]     <= '0;
                end else begin
                    cnt[n] <= cnt_next[n];
                end
            end
        end
    end

    // upper half of the window, writes are acked and dropped
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i.cyc & req_i.stb & req_i.adr[6] & ~ack_q;
        end
    end

    assign idx = reg_idx_t'(req_i.adr[5:2]);

    always_comb begin
        if (idx < IDX_RUNNING) begin
            rdata = {{(32-CNT_W){1'b0}}, latched[idx[SEL_W-1:0]]};
        end else if (idx == IDX_RUNNING) begin
            rdata = {{(32-NUM_CLK){1'b0}}, running};
        end else begin
            rdata = 32'd0;
        end
    end

    assign rsp_o.ack     = ack_q;
    assign rsp_o.dat     = rdata;
    assign clk_running_o = running;

endmodule

//--- src/surf_id_top.sv
`timescale 1ns/100ps
`include "surf_id_config.svh"

module surf_id_top (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [11:0] wb_adr_i,
    input  logic [3:0]  wb_sel_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        wb_err_o,
    output logic        wb_rty_o,
    input  logic        sys_clk_i,
    input  logic        gtp_clk_i,
    input  logic        rx_clk_i,
    input  logic        clk300_i
);

    import surf_id_pkg::*;

    wb_req_t                     req;
    wb_rsp_t                     id_rsp;
    wb_rsp_t                     mon_rsp;
    wb_rsp_t                     rsp;
    logic                        dna_bit;
    logic                        dna_load;
    logic                        dna_shift;
    logic [`SURF_NUM_CLKMON-1:0] clk_running;

    assign req.cyc = wb_cyc_i;
    assign req.stb = wb_stb_i;
    assign req.we  = wb_we_i;
    assign req.adr = wb_adr_i;
    assign req.sel = wb_sel_i;
    assign req.dat = wb_dat_i;

    surf_id_regs u_regs (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .req_i         (req),
        .rsp_o         (id_rsp),
        .dna_bit_i     (dna_bit),
        .dna_load_o    (dna_load),
        .dna_shift_o   (dna_shift),
        .clk_running_i (clk_running)
    );

    serial_id_reg u_dna (
        .wb_clk_i (wb_clk_i),
        .load_i   (dna_load),
        .shift_i  (dna_shift),
        .dout_o   (dna_bit)
    );

    // clock 3 is the 300 MHz reference
    clock_mon u_clockmon (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .req_i         (req),
        .rsp_o         (mon_rsp),
        .mon_clk_i     ({clk300_i, rx_clk_i, gtp_clk_i, sys_clk_i}),
        .clk_running_o (clk_running)
    );

    assign rsp      = wb_adr_i[6] ? mon_rsp : id_rsp;
    assign wb_ack_o = rsp.ack;
    assign wb_dat_o = rsp.dat;
    assign wb_err_o = 1'b0;
    assign wb_rty_o = 1'b0;

endmodule

//--- bench/surf_id_assert.sv
`timescale 1ns/100ps

module surf_id_assert (
    input logic wb_clk_i,
    input logic wb_rst_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic wb_err_o,
    input logic wb_rty_o
);

    // single cycle ack
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |-> !$past(wb_ack_o))
        else $error("ack high in two consecutive cycles");

    // every ack answers a request seen one cycle earlier
    a_ack_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |-> $past(wb_cyc_i & wb_stb_i))
        else $error("ack without cyc and stb in the previous cycle");

    a_no_err: assert property (@(posedge wb_clk_i) !wb_err_o && !wb_rty_o)
        else $error("err or rty asserted");

    a_ack_reset: assert property (@(posedge wb_clk_i) $past(wb_rst_i) |-> !wb_ack_o)
        else $error("ack high in the cycle after reset");

endmodule

bind surf_id_top surf_id_assert u_assert (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .wb_rty_o (wb_rty_o)
);

//--- bench/surf_id_tb.sv
`timescale 1ns/100ps
`include "surf_id_config.svh"

module surf_id_tb;

    localparam int WB_PERIOD   = 100;
    localparam int SYS_PERIOD  = 40;
    localparam int GTP_PERIOD  = 60;
    localparam int RX_PERIOD   = 250;
    localparam int ACK_TIMEOUT = 20;
    localparam int DNA_W       = `SURF_DNA_WIDTH;
    localparam int WINDOW      = `SURF_CLKMON_WINDOW;

    typedef struct {
        string       name;
        logic [11:0] adr;
        bit          we;
        logic [3:0]  sel;
        logic [31:0] wdat;
        logic [31:0] exp;
        int          tol;
        int          phase;
    } test_t;

    logic        wb_clk_i  = 1'b0;
    logic        sys_clk_i = 1'b0;
    logic        gtp_clk_i = 1'b0;
    logic        rx_clk_i  = 1'b0;
    logic        clk300_i;
    logic        wb_rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [11:0] wb_adr_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;
    logic        wb_rty_o;

    test_t tests[$];
    int    n_tests;
    int    n_fail;
    bit    aborted;
    int    run_cycles = 0;

    surf_id_top i_surf_id_top (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_sel_i  (wb_sel_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .wb_rty_o  (wb_rty_o),
        .sys_clk_i (sys_clk_i),
        .gtp_clk_i (gtp_clk_i),
        .rx_clk_i  (rx_clk_i),
        .clk300_i  (clk300_i)
    );

    always #(WB_PERIOD / 2) wb_clk_i = ~wb_clk_i;
    always #(SYS_PERIOD / 2) sys_clk_i = ~sys_clk_i;
    always #(GTP_PERIOD / 2) gtp_clk_i = ~gtp_clk_i;
    always #(RX_PERIOD / 2) rx_clk_i = ~rx_clk_i;

    // wb cycles since reset was released
    always @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    // one counted transition per prescale edges of the monitored clock
    function automatic int expected_count(input int period_ns);
        return WINDOW * WB_PERIOD / (period_ns * `SURF_CLKMON_PRESCALE);
    endfunction

    task automatic add_test(input string name, input logic [11:0] adr, input bit we,
                            input logic [3:0] sel, input logic [31:0] wdat,
                            input logic [31:0] exp, input int tol, input int phase);
        test_t t;
        t.name  = name;
        t.adr   = adr;
        t.we    = we;
        t.sel   = sel;
        t.wdat  = wdat;
        t.exp   = exp;
        t.tol   = tol;
        t.phase = phase;
        tests.push_back(t);
    endtask

    task automatic bus_access(input string name, input logic [11:0] adr, input bit we,
                              input logic [3:0] sel, input logic [31:0] wdat,
                              output logic [31:0] rdat, output bit ok);
        int waited;
        ok     = 1'b0;
        rdat   = '0;
        waited = 0;
        if (aborted) return;
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_sel_i = sel;
        wb_dat_i = wdat;
        while (!ok && waited < ACK_TIMEOUT) begin
            @(negedge wb_clk_i);
            waited++;
            if (wb_ack_o) begin
                ok   = 1'b1;
                rdat = wb_dat_o;
            end
        end
        // master drops stb after the edge that closes the ack cycle
        if (ok) begin
            @(negedge wb_clk_i);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!ok) begin
            $display("timeout: %s got no ack within %0d cycles", name, ACK_TIMEOUT);
            n_fail++;
            aborted = 1'b1;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act, input int tol);
        int diff;
        diff = int'(act) - int'(exp);
        if (diff > tol || diff < -tol) begin
            n_fail++;
            $display("ERROR %s: expected %h (+/- %0d), actual %h", name, exp, tol, act);
        end else begin
            $display("PASS  %s: %h", name, act);
        end
    endtask

    task automatic run_phase(input int phase);
        logic [31:0] rdat;
        bit          ok;
        foreach (tests[i]) begin
            if (tests[i].phase == phase && !aborted) begin
                n_tests++;
                bus_access(tests[i].name, tests[i].adr, tests[i].we, tests[i].sel,
                           tests[i].wdat, rdat, ok);
                if (ok && tests[i].we) begin
                    $display("PASS  %s: write acked", tests[i].name);
                end else if (ok) begin
                    check_value(tests[i].name, tests[i].exp, rdat, tests[i].tol);
                end
            end
        end
    endtask

    task automatic read_dna();
        logic [DNA_W-1:0] got;
        logic [31:0]      rdat;
        bit               ok;
        int               i;
        got = '0;
        n_tests++;
        bus_access("dna_load", 12'h008, 1'b1, 4'b1000, 32'h8000_0000, rdat, ok);
        for (i = 0; i < DNA_W && ok; i++) begin
            bus_access("dna_bit", 12'h008, 1'b0, 4'hf, 32'h0, rdat, ok);
            got[i] = rdat[0];
        end
        if (ok) begin
            if (got !== `SURF_DNA_VALUE) begin
                n_fail++;
                $display("ERROR dna_serial: expected %h, actual %h", `SURF_DNA_VALUE, got);
            end else begin
                $display("PASS  dna_serial: %h", got);
            end
        end
    endtask

    // stb stays up through the cycle after the ack, which must not ack again
    task automatic stb_held_read();
        int acks;
        int i;
        if (aborted) return;
        n_tests++;
        acks = 0;
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = 12'h000;
        wb_sel_i = 4'hf;
        for (i = 0; i < 3; i++) begin
            @(negedge wb_clk_i);
            if (wb_ack_o) begin
                acks++;
            end
            if (i == 1) begin
                wb_cyc_i = 1'b0;
                wb_stb_i = 1'b0;
            end
        end
        if (acks != 1) begin
            n_fail++;
            $display("ERROR stb_held: expected %0d acks, actual %0d acks", 1, acks);
        end else begin
            $display("PASS  stb_held: one ack");
        end
    endtask

    task automatic wait_windows();
        int waited;
        waited = 0;
        // two full windows plus the synchronizer delay
        while (run_cycles < 2 * WINDOW + 8 && waited < 4 * WINDOW) begin
            @(negedge wb_clk_i);
            waited++;
        end
        if (run_cycles < 2 * WINDOW + 8) begin
            n_tests++;
            n_fail++;
            aborted = 1'b1;
            $display("the monitor windows did not elapse in time");
        end
    endtask

    initial begin
        clk300_i = 1'b0;
        wb_rst_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = '0;
        wb_dat_i = '0;
        n_tests  = 0;
        n_fail   = 0;
        aborted  = 1'b0;

        add_test("device", 12'h000, 1'b0, 4'hf, 32'h0, `SURF_DEVICE, 0, 0);
        add_test("version", 12'h004, 1'b0, 4'hf, 32'h0, `SURF_VERSION, 0, 0);
        add_test("device_m10", 12'h010, 1'b0, 4'hf, 32'h0, `SURF_DEVICE, 0, 0);
        add_test("version_m14", 12'h014, 1'b0, 4'hf, 32'h0, `SURF_VERSION, 0, 0);
        add_test("device_m20", 12'h020, 1'b0, 4'hf, 32'h0, `SURF_DEVICE, 0, 0);
        add_test("version_m24", 12'h024, 1'b0, 4'hf, 32'h0, `SURF_VERSION, 0, 0);
        add_test("device_m30", 12'h030, 1'b0, 4'hf, 32'h0, `SURF_DEVICE, 0, 0);
        add_test("version_m34", 12'h034, 1'b0, 4'hf, 32'h0, `SURF_VERSION, 0, 0);
        add_test("dna_unloaded", 12'h008, 1'b0, 4'hf, 32'h0, 32'h0, 0, 0);
        add_test("dna_unloaded_next", 12'h008, 1'b0, 4'hf, 32'h0, 32'h0, 0, 0);
        add_test("wr_device", 12'h000, 1'b1, 4'hf, 32'hdead_beef, 32'h0, 0, 0);
        add_test("device_after_wr", 12'h000, 1'b0, 4'hf, 32'h0, `SURF_DEVICE, 0, 0);
        add_test("cnt_sys", 12'h040, 1'b0, 4'hf, 32'h0, expected_count(SYS_PERIOD), 2, 1);
        add_test("cnt_gtp", 12'h044, 1'b0, 4'hf, 32'h0, expected_count(GTP_PERIOD), 2, 1);
        add_test("cnt_rx", 12'h048, 1'b0, 4'hf, 32'h0, expected_count(RX_PERIOD), 2, 1);
        add_test("cnt_300", 12'h04c, 1'b0, 4'hf, 32'h0, 32'h0, 0, 1);
        add_test("running", 12'h050, 1'b0, 4'hf, 32'h0, 32'h7, 0, 1);
        add_test("status", 12'h00c, 1'b0, 4'hf, 32'h0, 32'h7, 0, 1);
        add_test("wr_cnt_gtp", 12'h044, 1'b1, 4'hf, 32'h0000_0fff, 32'h0, 0, 1);
        add_test("cnt_gtp_after_wr", 12'h044, 1'b0, 4'hf, 32'h0,
                 expected_count(GTP_PERIOD), 2, 1);

        repeat (16) @(negedge wb_clk_i);
        wb_rst_i = 1'b0;

        run_phase(0);
        read_dna();
        stb_held_read();
        wait_windows();
        run_phase(1);

        $display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_fail, n_fail);
        if (n_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- surf_id.f
+incdir+src
src/surf_id_pkg.sv
src/serial_id_reg.sv
src/surf_id_regs.sv
src/clock_mon.sv
src/surf_id_top.sv
bench/surf_id_assert.sv
bench/surf_id_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f surf_id.f --top-module surf_id_tb -o surf_id_sim

out=$(./obj_dir/surf_id_sim)
echo "$out"

# pass only if the testbench printed its pass line
echo "$out" | grep -q "^NO ERRORS$"
